// ==== rtl/stream_defs.svh ====
// width and depth macros for the frame bridge, included by the package and the RTL that sizes logic
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// bits per stream beat, one byte
`define STREAM_DATA_WIDTH 8

// log2 of the async FIFO depth
// 3 gives 8 entries, enough to ride out short bursts
`define FIFO_ADDR_WIDTH 3

// frame length counter width
// wraps silently past 65535 bytes
`define FRAME_LEN_WIDTH 16

`endif

// ==== rtl/stream_pkg.sv ====
// shared enums and structs for the frame bridge, imported by every RTL block and the testbench
`include "stream_defs.svh"

package stream_pkg;

    // command opcodes driven on the strobe input
    // every op carries one byte
    typedef enum logic [1:0] {
        OP_DATA  = 2'd0,
        OP_LAST  = 2'd1,
        OP_ABORT = 2'd2
    } frame_op_t;

    // one command, qualified by cmd_strobe
    typedef struct packed {
        frame_op_t                      op;
        logic [`STREAM_DATA_WIDTH-1:0]  data;
    } frame_cmd_t;

    // stream beat, also the FIFO storage word
    // user set means the frame is bad
    typedef struct packed {
        logic [`STREAM_DATA_WIDTH-1:0]  data;
        logic                           last;
        logic                           user;
    } stream_beat_t;

    // per-frame result from the checker
    typedef struct packed {
        logic [`FRAME_LEN_WIDTH-1:0]    length;
        logic [`STREAM_DATA_WIDTH-1:0]  checksum;
        logic                           bad;
    } frame_summary_t;

    // checker FSM
    typedef enum logic {
        ST_COLLECT,
        ST_REPORT
    } checker_state_t;

endpackage

// ==== rtl/frame_producer.sv ====
// input-domain frame producer, turns command strobes into valid/ready stream beats for the FIFO
`timescale 1ns/100ps

module frame_producer (
    input  logic                     input_clk,
    input  logic                     async_rst,
    input  stream_pkg::frame_cmd_t   cmd,
    input  logic                     cmd_strobe,
    output stream_pkg::stream_beat_t in_beat,
    output logic                     in_valid,
    input  logic                     in_ready
);

    import stream_pkg::*;

    // strobe lands in the beat register this edge
    logic accept;
    // strobe lost, register still holds an untransferred beat
    logic drop;
    // sticky bad mark for the frame in progress
    logic frame_bad;
    // op ends the frame
    logic cmd_ends_frame;

    // register free, or its beat leaves on this same edge
    assign accept = cmd_strobe & (~in_valid | in_ready);
    assign drop = cmd_strobe & in_valid & ~in_ready;

    // OP_LAST and OP_ABORT both close the frame
    assign cmd_ends_frame = (cmd.op != OP_DATA);

    // valid tracking
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_valid <= 1'b0;
        end else if (accept) begin
            in_valid <= 1'b1;
        end else if (in_ready) begin
            // beat transferred, or nothing was held
            in_valid <= 1'b0;
        end
    end

    // beat payload, only loaded on accept so it holds while stalled
    always_ff @(posedge input_clk) begin
        if (accept) begin
            in_beat.data <= cmd.data;
            in_beat.last <= cmd_ends_frame;
            // abort forces bad on its own beat
            in_beat.user <= frame_bad | (cmd.op == OP_ABORT);
        end
    end

    // bad flag
    // a drop marks the frame, the next beat carries it
    // cleared once a closing beat has been loaded
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            frame_bad <= 1'b0;
        end else if (drop) begin
            frame_bad <= 1'b1;
        end else if (accept && cmd_ends_frame) begin
            frame_bad <= 1'b0;
        end
    end

    // held beat must not change until the FIFO takes it
    property p_beat_stable;
        @(posedge input_clk) disable iff (async_rst)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_beat));
    endproperty

    a_beat_stable: assert property (p_beat_stable)
        else $error("producer beat changed while stalled");

endmodule

// ==== rtl/axis_async_fifo.sv ====
// dual-clock stream FIFO with Gray pointers, carries beats from input_clk into output_clk
`timescale 1ns/100ps
`include "stream_defs.svh"

module axis_async_fifo #(
    parameter int ADDR_WIDTH = `FIFO_ADDR_WIDTH
) (
    input  logic                     async_rst,
    input  logic                     input_clk,
    input  stream_pkg::stream_beat_t in_beat,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  logic                     output_clk,
    output stream_pkg::stream_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready
);

    import stream_pkg::*;

    localparam logic [ADDR_WIDTH:0] PTR_ONE = (ADDR_WIDTH+1)'(1);
    // entry count, in pointer width
    localparam logic [ADDR_WIDTH:0] DEPTH = PTR_ONE << ADDR_WIDTH;

    // pointers carry one extra wrap bit
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] wr_ptr_next;
    logic [ADDR_WIDTH:0] wr_gray;
    logic [ADDR_WIDTH:0] wr_gray_next;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic [ADDR_WIDTH:0] rd_ptr_next;
    logic [ADDR_WIDTH:0] rd_gray;
    logic [ADDR_WIDTH:0] rd_gray_next;

    // two-flop crossings of the Gray pointers
    logic [ADDR_WIDTH:0] wr_gray_sync1;
    logic [ADDR_WIDTH:0] wr_gray_sync2;
    logic [ADDR_WIDTH:0] rd_gray_sync1;
    logic [ADDR_WIDTH:0] rd_gray_sync2;
    // read pointer as seen by the write side, decoded
    logic [ADDR_WIDTH:0] rd_ptr_sync_bin;

    // per-domain reset chains, stage 3 is the local reset
    logic input_rst_sync1;
    logic input_rst_sync2;
    logic input_rst_sync3;
    logic output_rst_sync1;
    logic output_rst_sync2;
    logic output_rst_sync3;

    stream_beat_t mem [0:(2**ADDR_WIDTH)-1];

    logic full;
    logic empty;
    logic write;
    logic read;

    function automatic logic [ADDR_WIDTH:0] gray_to_bin(input logic [ADDR_WIDTH:0] gray);
        logic [ADDR_WIDTH:0] bin;
        bin[ADDR_WIDTH] = gray[ADDR_WIDTH];
        for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    // reset synchronizers
    // input side holds until the output side has left reset too
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            input_rst_sync1 <= 1'b1;
            input_rst_sync2 <= 1'b1;
            input_rst_sync3 <= 1'b1;
        end else begin
            input_rst_sync1 <= 1'b0;
            input_rst_sync2 <= input_rst_sync1 | output_rst_sync1;
            input_rst_sync3 <= input_rst_sync2;
        end
    end

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            output_rst_sync1 <= 1'b1;
            output_rst_sync2 <= 1'b1;
            output_rst_sync3 <= 1'b1;
        end else begin
            output_rst_sync1 <= 1'b0;
            output_rst_sync2 <= output_rst_sync1;
            output_rst_sync3 <= output_rst_sync2;
        end
    end

    // full when the top two Gray bits differ and the rest match
    assign full = (wr_gray == {~rd_gray_sync2[ADDR_WIDTH -: 2], rd_gray_sync2[ADDR_WIDTH-2:0]});
    // empty on exact Gray match
    assign empty = (rd_gray == wr_gray_sync2);

    // write side
    assign in_ready = ~full & ~input_rst_sync3;
    assign write = in_valid & in_ready;
    assign wr_ptr_next = wr_ptr + PTR_ONE;
    assign wr_gray_next = wr_ptr_next ^ (wr_ptr_next >> 1);

    always_ff @(posedge input_clk or posedge input_rst_sync3) begin
        if (input_rst_sync3) begin
            wr_ptr <= '0;
            wr_gray <= '0;
        end else if (write) begin
            wr_ptr <= wr_ptr_next;
            wr_gray <= wr_gray_next;
        end
    end

    always_ff @(posedge input_clk) begin
        if (write) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_beat;
        end
    end

    // read pointer into input domain
    always_ff @(posedge input_clk or posedge input_rst_sync3) begin
        if (input_rst_sync3) begin
            rd_gray_sync1 <= '0;
            rd_gray_sync2 <= '0;
        end else begin
            rd_gray_sync1 <= rd_gray;
            rd_gray_sync2 <= rd_gray_sync1;
        end
    end

    // write pointer into output domain
    always_ff @(posedge output_clk or posedge output_rst_sync3) begin
        if (output_rst_sync3) begin
            wr_gray_sync1 <= '0;
            wr_gray_sync2 <= '0;
        end else begin
            wr_gray_sync1 <= wr_gray;
            wr_gray_sync2 <= wr_gray_sync1;
        end
    end

    // read side
    // refill the output register when it is empty or being taken
    assign read = (out_ready | ~out_valid) & ~empty;
    assign rd_ptr_next = rd_ptr + PTR_ONE;
    assign rd_gray_next = rd_ptr_next ^ (rd_ptr_next >> 1);

    always_ff @(posedge output_clk or posedge output_rst_sync3) begin
        if (output_rst_sync3) begin
            rd_ptr <= '0;
            rd_gray <= '0;
            out_valid <= 1'b0;
        end else begin
            if (read) begin
                rd_ptr <= rd_ptr_next;
                rd_gray <= rd_gray_next;
            end
            if (out_ready | ~out_valid) begin
                out_valid <= ~empty;
            end
        end
    end

    always_ff @(posedge output_clk) begin
        if (read) begin
            out_beat <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // occupancy against the crossed read pointer never exceeds depth on a write
    assign rd_ptr_sync_bin = gray_to_bin(rd_gray_sync2);

    property p_no_overflow;
        @(posedge input_clk) disable iff (input_rst_sync3)
        write |-> ((wr_ptr - rd_ptr_sync_bin) < DEPTH);
    endproperty

    a_no_overflow: assert property (p_no_overflow)
        else $error("async FIFO written while full");

endmodule

// ==== rtl/frame_checker.sv ====
// output-domain frame checker, sums length and XOR checksum per frame and strobes a summary
`timescale 1ns/100ps
`include "stream_defs.svh"

module frame_checker (
    input  logic                       output_clk,
    input  logic                       async_rst,
    input  stream_pkg::stream_beat_t   out_beat,
    input  logic                       out_valid,
    output logic                       out_ready,
    output stream_pkg::frame_summary_t summary,
    output logic                       summary_strobe
);

    import stream_pkg::*;

    localparam int LEN_W = `FRAME_LEN_WIDTH;

    checker_state_t state;

    // running totals for the frame in progress
    logic [LEN_W-1:0]              len_acc;
    logic [`STREAM_DATA_WIDTH-1:0] csum_acc;
    logic                          bad_acc;

    // totals including the beat being taken
    logic [LEN_W-1:0]              len_next;
    logic [`STREAM_DATA_WIDTH-1:0] csum_next;
    logic                          bad_next;

    logic take;

    // only stall point, the single report cycle
    assign out_ready = (state == ST_COLLECT);
    assign take = out_valid & out_ready;

    assign len_next = len_acc + LEN_W'(1);
    assign csum_next = csum_acc ^ out_beat.data;
    assign bad_next = bad_acc | out_beat.user;

    // strobe is high for exactly the report cycle
    assign summary_strobe = (state == ST_REPORT);

    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            state <= ST_COLLECT;
            len_acc <= '0;
            csum_acc <= '0;
            bad_acc <= 1'b0;
        end else begin
            case (state)
                ST_COLLECT: begin
                    if (take) begin
                        if (out_beat.last) begin
                            // frame closed, start clean for the next one
                            state <= ST_REPORT;
                            len_acc <= '0;
                            csum_acc <= '0;
                            bad_acc <= 1'b0;
                        end else begin
                            len_acc <= len_next;
                            csum_acc <= csum_next;
                            bad_acc <= bad_next;
                        end
                    end
                end
                ST_REPORT: begin
                    state <= ST_COLLECT;
                end
                default: begin
                    state <= ST_COLLECT;
                end
            endcase
        end
    end

    // summary register, captured with the last beat
    always_ff @(posedge output_clk) begin
        if (take && out_beat.last) begin
            summary.length <= len_next;
            summary.checksum <= csum_next;
            summary.bad <= bad_next;
        end
    end

    // one pulse per frame, never back to back
    property p_strobe_single;
        @(posedge output_clk) disable iff (async_rst)
        summary_strobe |=> !summary_strobe;
    endproperty

    a_strobe_single: assert property (p_strobe_single)
        else $error("summary strobe held for two cycles");

endmodule

// ==== rtl/frame_bridge_top.sv ====
// top of the frame bridge, producer in input_clk, async FIFO, checker in output_clk
`timescale 1ns/100ps
`include "stream_defs.svh"

module frame_bridge_top (
    input  logic                       input_clk,
    input  logic                       output_clk,
    input  logic                       async_rst,
    input  stream_pkg::frame_cmd_t     cmd,
    input  logic                       cmd_strobe,
    output stream_pkg::frame_summary_t summary,
    output logic                       summary_strobe
);

    import stream_pkg::*;

    // producer side stream, input_clk
    stream_beat_t in_beat;
    logic         in_valid;
    logic         in_ready;

    // checker side stream, output_clk
    stream_beat_t out_beat;
    logic         out_valid;
    logic         out_ready;

    frame_producer u_producer (
        .input_clk  (input_clk),
        .async_rst  (async_rst),
        .cmd        (cmd),
        .cmd_strobe (cmd_strobe),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready)
    );

    // clock crossing
    axis_async_fifo #(
        .ADDR_WIDTH (`FIFO_ADDR_WIDTH)
    ) u_fifo (
        .async_rst  (async_rst),
        .input_clk  (input_clk),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .output_clk (output_clk),
        .out_beat   (out_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    frame_checker u_checker (
        .output_clk     (output_clk),
        .async_rst      (async_rst),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .summary        (summary),
        .summary_strobe (summary_strobe)
    );

endmodule

// ==== verif/frame_bridge_tb.sv ====
// testbench for the frame bridge, replays frame_testdata.txt commands and checks each frame summary
`timescale 1ns/100ps
`include "stream_defs.svh"

module frame_bridge_tb;

    import stream_pkg::*;

    // wait limits, in input_clk cycles
    localparam int SUMMARY_TIMEOUT = 2000;
    localparam int READY_TIMEOUT = 200;
    // quiet time before looking for stray summaries
    localparam int DRAIN_CYCLES = 100;
    // bytes in the random smoke frame
    localparam int SMOKE_LEN = 12;

    logic           input_clk;
    logic           output_clk;
    logic           async_rst;
    frame_cmd_t     cmd;
    logic           cmd_strobe;
    frame_summary_t summary;
    logic           summary_strobe;

    // summaries in arrival order
    frame_summary_t summary_q[$];

    frame_bridge_top DUT (
        .input_clk      (input_clk),
        .output_clk     (output_clk),
        .async_rst      (async_rst),
        .cmd            (cmd),
        .cmd_strobe     (cmd_strobe),
        .summary        (summary),
        .summary_strobe (summary_strobe)
    );

    // 100 MHz producer side
    initial begin
        input_clk = 1'b0;
        forever #5 input_clk = ~input_clk;
    end

    // 40 MHz checker side, slower so bursts back up
    initial begin
        output_clk = 1'b0;
        forever #12.5 output_clk = ~output_clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_summary_field(input string name, input frame_summary_t exp,
                                       input frame_summary_t act);
        if (act.length !== exp.length) begin
            report_failure($sformatf("Fail %s length expected %0d actual %0d",
                                     name, exp.length, act.length));
        end
        if (act.checksum !== exp.checksum) begin
            report_failure($sformatf("Fail %s checksum expected %02h actual %02h",
                                     name, exp.checksum, act.checksum));
        end
    endtask

    task automatic check_bad(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            report_failure($sformatf("Fail %s bad expected %0b actual %0b", name, exp, act));
        end
    endtask

    // entered and left 1 ns after an input_clk edge
    task automatic send_cmd(input frame_op_t op, input logic [7:0] data, input int gap);
        cmd.op = op;
        cmd.data = data;
        cmd_strobe = 1'b1;
        @(posedge input_clk);
        #1;
        cmd_strobe = 1'b0;
        // gap 0 leaves the strobe high into the next call
        repeat (gap) begin
            @(posedge input_clk);
            #1;
        end
    endtask

    task automatic take_summary(input string name, output frame_summary_t got);
        int waited;
        waited = 0;
        while (summary_q.size() == 0) begin
            @(posedge input_clk);
            #1;
            waited++;
            if (waited > SUMMARY_TIMEOUT) begin
                report_failure($sformatf("timed out waiting for the summary of %s", name));
            end
        end
        got = summary_q.pop_front();
    endtask

    // sampled mid-cycle where strobe and summary are settled
    task automatic watch_summaries();
        forever begin
            @(negedge output_clk);
            if (summary_strobe === 1'b1) begin
                summary_q.push_back(summary);
            end
        end
    endtask

    // FIFO input stays not ready until its reset chains release
    task automatic wait_fifo_ready();
        int waited;
        waited = 0;
        while (DUT.in_ready !== 1'b1) begin
            @(posedge input_clk);
            #1;
            waited++;
            if (waited > READY_TIMEOUT) begin
                report_failure("the FIFO never became ready after reset");
            end
        end
    endtask

    // random bytes, spaced gaps, expected length and XOR built alongside
    task automatic run_smoke_frame();
        logic [31:0]    seed;
        frame_summary_t exp_s;
        frame_summary_t got;
        frame_op_t      op;
        seed = 32'hcad;
        exp_s = '0;
        for (int i = 0; i < SMOKE_LEN; i++) begin
            seed = xorshift(seed);
            op = (i == SMOKE_LEN - 1) ? OP_LAST : OP_DATA;
            exp_s.checksum = exp_s.checksum ^ seed[7:0];
            send_cmd(op, seed[7:0], 4 + int'(seed[9:8]));
        end
        exp_s.length = `FRAME_LEN_WIDTH'(SMOKE_LEN);
        take_summary("smoke frame", got);
        check_summary_field("smoke frame", exp_s, got);
        check_bad("smoke frame", 1'b0, got.bad);
    endtask

    initial begin
        int             fd;
        string          line;
        byte            kind;
        int             n;
        int             op_val;
        int             data_val;
        int             gap_val;
        int             rep_val;
        int             len_val;
        int             csum_val;
        int             bad_val;
        int             frame_idx;
        string          name;
        frame_summary_t exp_s;
        frame_summary_t got;

        async_rst = 1'b1;
        cmd = '0;
        cmd_strobe = 1'b0;
        frame_idx = 0;
        fork
            watch_summaries();
        join_none
        repeat (16) @(posedge input_clk);
        #1;
        async_rst = 1'b0;
        wait_fifo_ready();

        fd = $fopen("verif/frame_testdata.txt", "r");
        if (fd == 0) begin
            report_failure("could not open verif/frame_testdata.txt");
        end
        while ($fgets(line, fd) != 0) begin
            // blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            kind = line.getc(0);
            name = $sformatf("frame %0d", frame_idx);
            if (kind == "C") begin
                n = $sscanf(line, "%c %h %h %d %d", kind, op_val, data_val, gap_val, rep_val);
                if (n != 5) begin
                    report_failure($sformatf("bad command line in testdata: %s", line));
                end
                repeat (rep_val) send_cmd(frame_op_t'(op_val[1:0]), data_val[7:0], gap_val);
            end else if (kind == "S") begin
                n = $sscanf(line, "%c %d %h %d", kind, len_val, csum_val, bad_val);
                if (n != 4) begin
                    report_failure($sformatf("bad summary line in testdata: %s", line));
                end
                exp_s.length = len_val[`FRAME_LEN_WIDTH-1:0];
                exp_s.checksum = csum_val[7:0];
                exp_s.bad = bad_val[0];
                take_summary(name, got);
                check_summary_field(name, exp_s, got);
                check_bad(name, exp_s.bad, got.bad);
                frame_idx++;
            end else if (kind == "B") begin
                // overrun frame, only the flag is defined
                n = $sscanf(line, "%c %d", kind, bad_val);
                if (n != 2) begin
                    report_failure($sformatf("bad flag line in testdata: %s", line));
                end
                take_summary(name, got);
                check_bad(name, bad_val[0], got.bad);
                frame_idx++;
            end else begin
                report_failure($sformatf("unknown line kind in testdata: %s", line));
            end
        end
        $fclose(fd);

        run_smoke_frame();

        // one summary per frame, nothing left over
        repeat (DRAIN_CYCLES) @(posedge output_clk);
        if (summary_q.size() != 0) begin
            report_failure($sformatf("%0d summaries arrived with no frame to match",
                                     summary_q.size()));
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

// ==== verif/frame_testdata.txt ====
# C op data gap rep: op 0 data 1 last 2 abort, data hex, idle input_clk cycles after, repeat count
# S len csum bad: expected summary, length decimal, checksum hex; B bad: expected flag only
C 0 12 4 1
C 0 34 4 1
C 0 56 5 1
C 0 78 6 1
C 1 9a 4 1
S 5 92 0
C 1 a5 4 1
S 1 a5 0
C 0 0f 4 1
C 0 f0 4 1
C 2 3c 4 1
S 3 c3 1
C 0 ee 0 29
C 0 ee 40 1
C 1 55 4 1
B 1
C 0 01 4 1
C 0 02 4 1
C 0 04 4 1
C 1 08 4 1
S 4 0f 0
C 0 aa 5 1
C 1 55 4 1
S 2 ff 0
C 0 c3 4 1
C 0 3c 4 1
C 0 11 4 1
C 1 22 6 1
S 4 cc 0
C 2 7e 4 1
S 1 7e 1
C 1 81 4 1
S 1 81 0

// ==== vlog.f ====
+incdir+rtl
rtl/stream_pkg.sv
rtl/frame_producer.sv
rtl/axis_async_fifo.sv
rtl/frame_checker.sv
rtl/frame_bridge_top.sv
verif/frame_bridge_tb.sv

// ==== Makefile ====
TOP = frame_bridge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -f vlog.f -Mdir obj_dir
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf obj_dir
